// File: link_pkg.sv
/* Shared sizing, encodings and word formats for the simplex streaming link
   Every link module and the testbench reach these through link_pkg:: names */
package link_pkg;

	// --------------------------------------------------------------------------
	// Link sizing
	// --------------------------------------------------------------------------
	localparam int LINK_TDATA_FACTOR = 4;                       // 64-bit lanes
	localparam int LINK_DWIDTH       = 64 * LINK_TDATA_FACTOR;  // User beat width
	localparam int LINK_FIFO_DEPTH   = 8;                       // Follower buffer entries
	localparam int LINK_FIFO_AW      = $clog2(LINK_FIFO_DEPTH);
	localparam int LINK_CRED_W       = $clog2(LINK_FIFO_DEPTH + 1);
	localparam int LINK_PHY_LAT      = 2;                       // Wire latency in cycles

	// Occupancy of a full buffer, which is also the leader's starting credit
	localparam logic [LINK_CRED_W-1:0] LINK_FIFO_FULL = LINK_CRED_W'(LINK_FIFO_DEPTH);

	// Delay divisors
	localparam int LINK_RATE_FULL = 1;  // gen2
	localparam int LINK_RATE_HALF = 2;

	localparam logic [31:0] LINK_ALIGN_MARKER = 32'hA11C_5EED;

	// Kind bit of a phy word
	localparam logic LINK_KIND_DATA = 1'b0;
	localparam logic LINK_KIND_CTRL = 1'b1;

	// --------------------------------------------------------------------------
	// Word formats
	// --------------------------------------------------------------------------
	typedef struct packed {
		logic [LINK_DWIDTH-49:0] pad;
		logic [31:0]             marker;  // LINK_ALIGN_MARKER on the align word
		logic [15:0]             count;   // Credits held by the leader when sent
	} link_ctrl_word_t;

	// Same 256 bits, read as user data or as a control word by the kind bit
	typedef union packed {
		logic [LINK_DWIDTH-1:0] data;
		link_ctrl_word_t        ctrl;
	} link_payload_u;

	typedef struct packed {
		logic          valid;
		logic          kind;
		link_payload_u payload;
	} link_phy_word_t;

	// Single strobe for now, a count field can go in front of it later
	typedef struct packed {
		logic strobe;
	} link_credit_t;

endpackage

// File: link_ctrl.sv
/* Link controller: staged delay value, rate scaling, lane online flags and
   the leader alignment hold-off that gates the transmitter */
`timescale 1ns/1ps

module link_ctrl (
	input  logic                                   i_m_wr_clk,
	input  logic                                   i_m_wr_rst_n,
	input  logic [link_pkg::LINK_TDATA_FACTOR-1:0] i_ldr_tx_en,
	input  logic [link_pkg::LINK_TDATA_FACTOR-1:0] i_fol_tx_en,
	input  logic [31:0]                            i_delay_x,
	input  logic                                   i_gen2_mode,
	output logic                                   o_ldr_online,
	output logic                                   o_fol_online,
	output logic                                   o_align_done,
	output logic                                   o_rate_half
);

	logic [15:0] delay_r1;
	logic [15:0] delay_r2;
	logic [15:0] delay_scaled;
	logic [15:0] holdoff_cnt;
	logic        align_r;

	// Two register stages on the delay, only the low half is meaningful
	always_ff @(posedge i_m_wr_clk)
	begin
		if (!i_m_wr_rst_n)
		begin
			delay_r1 <= '0;
			delay_r2 <= '0;
		end
		else
		begin
			delay_r1 <= i_delay_x[15:0];
			delay_r2 <= delay_r1;
		end
	end

	assign o_rate_half  = ~i_gen2_mode;  // Half rate unless gen2
	assign delay_scaled = o_rate_half ? delay_r2 / 16'(link_pkg::LINK_RATE_HALF)
	                                  : delay_r2 / 16'(link_pkg::LINK_RATE_FULL);

	// All lanes must be enabled for a side to count as online
	always_ff @(posedge i_m_wr_clk)
	begin
		if (!i_m_wr_rst_n)
		begin
			o_ldr_online <= 1'b0;
			o_fol_online <= 1'b0;
		end
		else
		begin
			o_ldr_online <= &i_ldr_tx_en;
			o_fol_online <= &i_fol_tx_en;
		end
	end

	// --------------------------------------------------------------------------
	// Hold-off counter, restarts whenever the leader drops offline
	// --------------------------------------------------------------------------
	always_ff @(posedge i_m_wr_clk)
	begin
		if (!i_m_wr_rst_n || !o_ldr_online)
		begin
			holdoff_cnt <= '0;
			align_r     <= 1'b0;
		end
		else if (!align_r)
		begin
			holdoff_cnt <= holdoff_cnt + 16'd1;  // Cycles online so far
			if ({1'b0, holdoff_cnt} + 17'd1 >= {1'b0, delay_scaled})
				align_r <= 1'b1;
		end
	end

	assign o_align_done = align_r & o_ldr_online;  // Falls with online

endmodule

// File: link_tx.sv
/* Leader transmitter: sends the align marker once, then user beats as data
   words, paced in half rate and limited by credits from the follower */
`timescale 1ns/1ps

module link_tx (
	input  logic                             i_m_wr_clk,
	input  logic                             i_m_wr_rst_n,
	input  logic [link_pkg::LINK_DWIDTH-1:0] i_tdata,
	input  logic                             i_tvalid,
	output logic                             o_tready,
	input  logic                             i_align_done,
	input  logic                             i_fol_online,
	input  logic                             i_rate_half,
	input  link_pkg::link_credit_t           i_credit,
	output link_pkg::link_phy_word_t         o_phy
);

	logic [link_pkg::LINK_CRED_W-1:0] credits;
	logic                             marker_sent;
	logic                             pace_phase;
	logic                             send_marker;
	logic                             accept;
	logic                             phy_valid;
	logic                             phy_kind;
	link_pkg::link_payload_u          phy_payload;
	link_pkg::link_ctrl_word_t        marker_word;

	assign send_marker = i_align_done & i_fol_online & ~marker_sent;
	assign o_tready    = i_align_done & marker_sent & (credits != '0)
	                   & (~i_rate_half | pace_phase);
	assign accept      = i_tvalid & o_tready;

	// --------------------------------------------------------------------------
	// Control state
	// --------------------------------------------------------------------------
	always_ff @(posedge i_m_wr_clk)
	begin
		if (!i_m_wr_rst_n)
		begin
			credits     <= link_pkg::LINK_FIFO_FULL;  // One per follower entry
			marker_sent <= 1'b0;
			pace_phase  <= 1'b0;
		end
		else
		begin
			// Marker goes out again after a realignment
			if (!i_align_done)
				marker_sent <= 1'b0;
			else if (send_marker)
				marker_sent <= 1'b1;

			pace_phase <= i_rate_half ? ~pace_phase : 1'b1;  // Open every other cycle

			case ({accept, i_credit.strobe})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;  // Both or neither
			endcase
		end
	end

	always_comb
	begin
		marker_word        = '0;
		marker_word.marker = link_pkg::LINK_ALIGN_MARKER;
		marker_word.count  = 16'(credits);
	end

	// Outgoing word, sent the cycle after the marker decision or the accept
	always_ff @(posedge i_m_wr_clk)
	begin
		if (!i_m_wr_rst_n)
		begin
			phy_valid <= 1'b0;
			phy_kind  <= link_pkg::LINK_KIND_DATA;
		end
		else
		begin
			phy_valid <= send_marker | accept;
			phy_kind  <= send_marker ? link_pkg::LINK_KIND_CTRL : link_pkg::LINK_KIND_DATA;
		end
	end

	always_ff @(posedge i_m_wr_clk)
	begin
		if (send_marker)
			phy_payload.ctrl <= marker_word;
		else if (accept)
			phy_payload.data <= i_tdata;
	end

	assign o_phy = '{valid: phy_valid, kind: phy_kind, payload: phy_payload};

endmodule

// File: link_phy_wire.sv
/* Fixed-latency model of the physical lanes, phy words run forward and
   credit strobes run back, several of each can be in flight */
`timescale 1ns/1ps

module link_phy_wire (
	input  logic                     i_m_wr_clk,
	input  logic                     i_m_wr_rst_n,
	input  link_pkg::link_phy_word_t i_fwd,
	output link_pkg::link_phy_word_t o_fwd,
	input  link_pkg::link_credit_t   i_bwd,
	output link_pkg::link_credit_t   o_bwd
);

	link_pkg::link_phy_word_t fwd_pipe [link_pkg::LINK_PHY_LAT];
	link_pkg::link_credit_t   bwd_pipe [link_pkg::LINK_PHY_LAT];

	// Forward lanes, only the valid bits are cleared
	always_ff @(posedge i_m_wr_clk)
	begin
		fwd_pipe[0] <= i_fwd;
		for (int i = 1; i < link_pkg::LINK_PHY_LAT; i++)
		begin
			fwd_pipe[i] <= fwd_pipe[i-1];
		end
		if (!i_m_wr_rst_n)
		begin
			for (int i = 0; i < link_pkg::LINK_PHY_LAT; i++)
			begin
				fwd_pipe[i].valid <= 1'b0;
			end
		end
	end

	// Credit return lane
	always_ff @(posedge i_m_wr_clk)
	begin
		if (!i_m_wr_rst_n)
		begin
			for (int i = 0; i < link_pkg::LINK_PHY_LAT; i++)
			begin
				bwd_pipe[i] <= '0;
			end
		end
		else
		begin
			bwd_pipe[0] <= i_bwd;
			for (int i = 1; i < link_pkg::LINK_PHY_LAT; i++)
			begin
				bwd_pipe[i] <= bwd_pipe[i-1];
			end
		end
	end

	assign o_fwd = fwd_pipe[link_pkg::LINK_PHY_LAT-1];
	assign o_bwd = bwd_pipe[link_pkg::LINK_PHY_LAT-1];

endmodule

// File: link_fifo.sv
/* First-word-fall-through buffer for beats arriving at the follower
   Head entry is visible on o_rdata whenever o_empty is low */
`timescale 1ns/1ps

module link_fifo (
	input  logic                             i_m_wr_clk,
	input  logic                             i_m_wr_rst_n,
	input  logic                             i_push,
	input  logic [link_pkg::LINK_DWIDTH-1:0] i_wdata,
	input  logic                             i_pop,
	output logic [link_pkg::LINK_DWIDTH-1:0] o_rdata,
	output logic                             o_empty
);

	logic [link_pkg::LINK_DWIDTH-1:0]  mem [link_pkg::LINK_FIFO_DEPTH];
	logic [link_pkg::LINK_FIFO_AW-1:0] wr_ptr;
	logic [link_pkg::LINK_FIFO_AW-1:0] rd_ptr;
	logic [link_pkg::LINK_CRED_W-1:0]  count;
	logic                              do_push;
	logic                              do_pop;

	// Credits keep the leader from ever pushing into a full buffer
	assign do_push = i_push & (count != link_pkg::LINK_FIFO_FULL);
	assign do_pop  = i_pop & (count != '0);

	always_ff @(posedge i_m_wr_clk)
	begin
		if (do_push)
			mem[wr_ptr] <= i_wdata;
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge i_m_wr_clk)
	begin
		if (!i_m_wr_rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign o_rdata = mem[rd_ptr];
	assign o_empty = (count == '0);

endmodule

// File: link_rx.sv
/* Follower receiver: decodes phy words, aligns on the marker, buffers data
   beats for the user and returns one credit strobe per delivered beat */
`timescale 1ns/1ps

module link_rx (
	input  logic                             i_m_wr_clk,
	input  logic                             i_m_wr_rst_n,
	input  link_pkg::link_phy_word_t         i_phy,
	output logic [link_pkg::LINK_DWIDTH-1:0] o_tdata,
	output logic                             o_tvalid,
	input  logic                             i_tready,
	output logic                             o_align_done,
	output link_pkg::link_credit_t           o_credit
);

	logic marker_hit;
	logic data_hit;
	logic align_r;
	logic fifo_empty;
	logic fifo_pop;
	logic credit_r;

	// --------------------------------------------------------------------------
	// Word decode
	// --------------------------------------------------------------------------
	assign marker_hit = i_phy.valid && (i_phy.kind == link_pkg::LINK_KIND_CTRL)
	                 && (i_phy.payload.ctrl.marker == link_pkg::LINK_ALIGN_MARKER);

	// Data ahead of alignment is dropped
	assign data_hit = i_phy.valid && (i_phy.kind == link_pkg::LINK_KIND_DATA) && align_r;

	always_ff @(posedge i_m_wr_clk)
	begin
		if (!i_m_wr_rst_n)
		begin
			align_r  <= 1'b0;
			credit_r <= 1'b0;
		end
		else
		begin
			if (marker_hit)
				align_r <= 1'b1;  // Sticky until reset
			credit_r <= fifo_pop;  // One strobe per beat handed out
		end
	end

	link_fifo i_link_fifo (
		.i_m_wr_clk   (i_m_wr_clk),
		.i_m_wr_rst_n (i_m_wr_rst_n),
		.i_push       (data_hit),
		.i_wdata      (i_phy.payload.data),
		.i_pop        (fifo_pop),
		.o_rdata      (o_tdata),
		.o_empty      (fifo_empty)
	);

	assign o_tvalid     = ~fifo_empty;
	assign fifo_pop     = o_tvalid & i_tready;
	assign o_align_done = align_r;
	assign o_credit     = '{strobe: credit_r};

endmodule

// File: link_simplex_top.sv
/* Simplex link top, leader transmitter to follower receiver over the wire
   model, with the link controller gating alignment */
`timescale 1ns/1ps

module link_simplex_top (
	input  logic                                   i_m_wr_clk,
	input  logic                                   i_m_wr_rst_n,

	// Leader user port
	input  logic [link_pkg::LINK_DWIDTH-1:0]       i_tx_tdata,
	input  logic                                   i_tx_tvalid,
	output logic                                   o_tx_tready,

	// Follower user port
	output logic [link_pkg::LINK_DWIDTH-1:0]       o_rx_tdata,
	output logic                                   o_rx_tvalid,
	input  logic                                   i_rx_tready,

	// Control and status
	input  logic [link_pkg::LINK_TDATA_FACTOR-1:0] i_ldr_tx_en,
	input  logic [link_pkg::LINK_TDATA_FACTOR-1:0] i_fol_tx_en,
	input  logic [31:0]                            i_delay_x,
	input  logic                                   i_gen2_mode,
	output logic                                   o_ldr_online,
	output logic                                   o_fol_online,
	output logic                                   o_ldr_align_done,
	output logic                                   o_fol_align_done
);

	link_pkg::link_phy_word_t phy_tx;      // Leader side of the wire
	link_pkg::link_phy_word_t phy_rx;      // Follower side of the wire
	link_pkg::link_credit_t   credit_rx;
	link_pkg::link_credit_t   credit_tx;
	logic                     rate_half;

	link_ctrl i_link_ctrl (
		.i_m_wr_clk   (i_m_wr_clk),
		.i_m_wr_rst_n (i_m_wr_rst_n),
		.i_ldr_tx_en  (i_ldr_tx_en),
		.i_fol_tx_en  (i_fol_tx_en),
		.i_delay_x    (i_delay_x),
		.i_gen2_mode  (i_gen2_mode),
		.o_ldr_online (o_ldr_online),
		.o_fol_online (o_fol_online),
		.o_align_done (o_ldr_align_done),
		.o_rate_half  (rate_half)
	);

	link_tx i_link_tx (
		.i_m_wr_clk   (i_m_wr_clk),
		.i_m_wr_rst_n (i_m_wr_rst_n),
		.i_tdata      (i_tx_tdata),
		.i_tvalid     (i_tx_tvalid),
		.o_tready     (o_tx_tready),
		.i_align_done (o_ldr_align_done),
		.i_fol_online (o_fol_online),
		.i_rate_half  (rate_half),
		.i_credit     (credit_tx),
		.o_phy        (phy_tx)
	);

	// ---------------------------------------------------------------------------
	// Physical lanes
	// ---------------------------------------------------------------------------
	link_phy_wire i_link_phy_wire (
		.i_m_wr_clk   (i_m_wr_clk),
		.i_m_wr_rst_n (i_m_wr_rst_n),
		.i_fwd        (phy_tx),
		.o_fwd        (phy_rx),
		.i_bwd        (credit_rx),
		.o_bwd        (credit_tx)
	);

	link_rx i_link_rx (
		.i_m_wr_clk   (i_m_wr_clk),
		.i_m_wr_rst_n (i_m_wr_rst_n),
		.i_phy        (phy_rx),
		.o_tdata      (o_rx_tdata),
		.o_tvalid     (o_rx_tvalid),
		.i_tready     (i_rx_tready),
		.o_align_done (o_fol_align_done),
		.o_credit     (credit_rx)
	);

endmodule

// File: link_simplex_chk.sv
/* Protocol and timing rules of the simplex link, bound onto the top level
   Each failing rule raises an error and bumps a count the testbench watches */
`timescale 1ns/1ps

module link_simplex_chk (
	input  logic                                   i_m_wr_clk,
	input  logic                                   i_m_wr_rst_n,
	input  logic                                   i_tx_tready,
	input  logic [link_pkg::LINK_DWIDTH-1:0]       i_rx_tdata,
	input  logic                                   i_rx_tvalid,
	input  logic                                   i_rx_tready,
	input  logic [link_pkg::LINK_TDATA_FACTOR-1:0] i_ldr_tx_en,
	input  logic [link_pkg::LINK_TDATA_FACTOR-1:0] i_fol_tx_en,
	input  logic                                   i_gen2_mode,
	input  logic                                   i_ldr_online,
	input  logic                                   i_fol_online,
	input  logic                                   i_ldr_align_done,
	input  logic                                   i_fol_align_done
);

	int err_count = 0;

	// Online flags are the registered AND of the lane enables
	online_follows_en: assert property (@(posedge i_m_wr_clk) disable iff (!i_m_wr_rst_n)
		(i_ldr_online == $past(&i_ldr_tx_en)) && (i_fol_online == $past(&i_fol_tx_en)))
		else begin $error("online flag does not follow its lane enables"); err_count++; end

	// Flag is registered, never up in the first online cycle
	align_not_early: assert property (@(posedge i_m_wr_clk) disable iff (!i_m_wr_rst_n)
		$rose(i_ldr_align_done) |-> $past(i_ldr_online))
		else begin $error("leader aligned in its first online cycle"); err_count++; end

	// Marker reaches the follower one wire trip plus a cycle after ready opens
	ready_needs_align: assert property (@(posedge i_m_wr_clk) disable iff (!i_m_wr_rst_n)
		i_tx_tready |-> ##(link_pkg::LINK_PHY_LAT + 1) i_fol_align_done)
		else begin $error("follower not aligned after the leader became ready"); err_count++; end

	rx_needs_align: assert property (@(posedge i_m_wr_clk) disable iff (!i_m_wr_rst_n)
		i_rx_tvalid |-> i_fol_align_done)
		else begin $error("follower delivered data before alignment"); err_count++; end

	// ------------------------------------------------------------------------
	// Back-pressure and pacing
	// ------------------------------------------------------------------------
	stall_holds_beat: assert property (@(posedge i_m_wr_clk) disable iff (!i_m_wr_rst_n)
		i_rx_tvalid && !i_rx_tready |=> i_rx_tvalid && $stable(i_rx_tdata))
		else begin $error("stalled follower beat changed or vanished"); err_count++; end

	half_rate_gap: assert property (@(posedge i_m_wr_clk) disable iff (!i_m_wr_rst_n)
		!i_gen2_mode && $past(!i_gen2_mode) && $past(i_tx_tready) |-> !i_tx_tready)
		else begin $error("ready on two cycles in a row at half rate"); err_count++; end

endmodule

// File: tb_clk_gen.sv
/* Testbench clock and reset source, 40 ns clock period with the
   synchronous reset held low for the first three cycles */
`timescale 1ns/1ps

module tb_clk_gen (
	output logic o_m_wr_clk,
	output logic o_m_wr_rst_n
);

	localparam int HALF_PERIOD_NS = 20;
	localparam int RESET_CYCLES   = 3;

	initial
	begin
		o_m_wr_clk = 1'b0;
		forever #HALF_PERIOD_NS o_m_wr_clk = ~o_m_wr_clk;
	end

	initial
	begin
		o_m_wr_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_m_wr_clk);
		@(negedge o_m_wr_clk);
		o_m_wr_rst_n = 1'b1;  // Released on a falling edge
	end

endmodule

// File: tb_link_simplex.sv
/* Testbench for the simplex link, runs four phases of rate and delay settings
   with random back-pressure and scoreboards every beat end to end */
`timescale 1ns/1ps

module tb_link_simplex;

	localparam int          CLK_PERIOD_NS    = 40;
	localparam int          BEATS_PER_PHASE  = 40;
	localparam int          NUM_PHASES       = 4;
	localparam int          MAX_DELAY        = 27;
	localparam int          CYC_PER_BEAT_MAX = 16;  // Half rate, stalls and phase setup
	localparam int          WATCHDOG_CYCLES  = NUM_PHASES * BEATS_PER_PHASE * CYC_PER_BEAT_MAX
	                                         + MAX_DELAY;
	localparam int          STALL_CYCLES     = 3 * link_pkg::LINK_FIFO_DEPTH;
	localparam logic [31:0] SEED             = 32'hc413_727d;

	logic                                   clk;
	logic                                   rst_n;
	logic [link_pkg::LINK_DWIDTH-1:0]       tx_tdata;
	logic                                   tx_tvalid;
	logic                                   tx_tready;
	logic [link_pkg::LINK_DWIDTH-1:0]       rx_tdata;
	logic                                   rx_tvalid;
	logic                                   rx_tready;
	logic [link_pkg::LINK_TDATA_FACTOR-1:0] ldr_tx_en;
	logic [link_pkg::LINK_TDATA_FACTOR-1:0] fol_tx_en;
	logic [31:0]                            delay_x;
	logic                                   gen2_mode;
	logic                                   ldr_online;
	logic                                   fol_online;
	logic                                   ldr_align_done;
	logic                                   fol_align_done;

	int                               seed;
	logic [link_pkg::LINK_DWIDTH-1:0] ref_q [$];  // Accepted, not yet delivered
	logic [link_pkg::LINK_DWIDTH-1:0] exp_beat;
	int                               accepted_cnt = 0;
	int                               delivered_cnt = 0;
	int                               target_cnt = 0;
	int                               hold_cnt = 0;
	int                               exp_holdoff = 1;
	int                               holdoff_seen = 0;
	logic                             align_prev = 1'b0;
	logic                             beat_taken = 1'b0;

	tb_clk_gen i_tb_clk_gen (
		.o_m_wr_clk   (clk),
		.o_m_wr_rst_n (rst_n)
	);

	link_simplex_top i_link_simplex_top (
		.i_m_wr_clk       (clk),
		.i_m_wr_rst_n     (rst_n),
		.i_tx_tdata       (tx_tdata),
		.i_tx_tvalid      (tx_tvalid),
		.o_tx_tready      (tx_tready),
		.o_rx_tdata       (rx_tdata),
		.o_rx_tvalid      (rx_tvalid),
		.i_rx_tready      (rx_tready),
		.i_ldr_tx_en      (ldr_tx_en),
		.i_fol_tx_en      (fol_tx_en),
		.i_delay_x        (delay_x),
		.i_gen2_mode      (gen2_mode),
		.o_ldr_online     (ldr_online),
		.o_fol_online     (fol_online),
		.o_ldr_align_done (ldr_align_done),
		.o_fol_align_done (fol_align_done)
	);

	bind link_simplex_top link_simplex_chk i_link_simplex_chk (
		.i_m_wr_clk       (i_m_wr_clk),
		.i_m_wr_rst_n     (i_m_wr_rst_n),
		.i_tx_tready      (o_tx_tready),
		.i_rx_tdata       (o_rx_tdata),
		.i_rx_tvalid      (o_rx_tvalid),
		.i_rx_tready      (i_rx_tready),
		.i_ldr_tx_en      (i_ldr_tx_en),
		.i_fol_tx_en      (i_fol_tx_en),
		.i_gen2_mode      (i_gen2_mode),
		.i_ldr_online     (o_ldr_online),
		.i_fol_online     (o_fol_online),
		.i_ldr_align_done (o_ldr_align_done),
		.i_fol_align_done (o_fol_align_done)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1, "run stopped at the first failure");
	endtask

	function automatic logic [link_pkg::LINK_DWIDTH-1:0] random_beat();
		logic [link_pkg::LINK_DWIDTH-1:0] beat;
		for (int k = 0; k < link_pkg::LINK_DWIDTH / 32; k++)
			beat[k*32 +: 32] = $random(seed);
		return beat;
	endfunction

	// One falling-edge step of the user ports, a beat stays put until taken
	task automatic drive_cycle(input logic want_data);
		logic [31:0] r;
		r = $random(seed);
		if (!tx_tvalid || beat_taken)
		begin
			tx_tvalid = want_data && (accepted_cnt < target_cnt) && (r[1:0] != 2'b00);
			if (tx_tvalid)
				tx_tdata = random_beat();
		end
		if (hold_cnt != 0)
		begin
			rx_tready = 1'b0;
			hold_cnt--;
		end
		else
		begin
			if (r[8:4] == 5'd0)
				hold_cnt = STALL_CYCLES;  // Long stall now and then
			rx_tready = r[9] | r[10];
		end
	endtask

	// --------------------------------------------------------------------------
	// One phase: bring lanes up, stream beats, drain, drop one lane
	// --------------------------------------------------------------------------
	task automatic run_phase(input logic gen2, input logic [15:0] delay, input int lane);
		logic [31:0] r;
		int          scaled;
		int          i;
		r           = $random(seed);
		gen2_mode   = gen2;
		delay_x     = {r[31:16], delay};  // Upper half is ignored by the link
		scaled      = gen2 ? int'(delay) : int'(delay) / 2;
		exp_holdoff = (scaled == 0) ? 1 : scaled;
		repeat (3) @(negedge clk);  // Delay stages settle while offline
		fol_tx_en = '1;
		for (i = 0; i < link_pkg::LINK_TDATA_FACTOR; i++)
		begin
			ldr_tx_en[i] = 1'b1;  // Online only once the last lane is up
			@(negedge clk);
		end
		target_cnt = accepted_cnt + BEATS_PER_PHASE;
		hold_cnt   = STALL_CYCLES;  // Fill the follower buffer first
		while (accepted_cnt < target_cnt)
		begin
			drive_cycle(1'b1);
			@(negedge clk);
		end
		while (delivered_cnt < accepted_cnt)
		begin
			drive_cycle(1'b0);
			@(negedge clk);
		end
		repeat (2 * link_pkg::LINK_PHY_LAT + 2) @(negedge clk);  // Last credits home
		ldr_tx_en[lane] = 1'b0;
		fol_tx_en[lane] = 1'b0;
		repeat (2) @(negedge clk);
		assert (!ldr_online && !fol_online && !ldr_align_done && !tx_tready)
			else abort_run("link stayed online after a lane was dropped");
		ldr_tx_en = '0;
		fol_tx_en = '0;
	endtask

	// Scoreboard, samples the transfer decided at this edge
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			beat_taken = tx_tvalid && tx_tready;
			if (beat_taken)
			begin
				ref_q.push_back(tx_tdata);
				accepted_cnt++;
			end
			if (rx_tvalid && rx_tready)
			begin
				assert (ref_q.size() != 0)
					else abort_run($sformatf("error at %0t ns: beat with none pending", $time));
				exp_beat = ref_q.pop_front();
				assert (rx_tdata == exp_beat)
					else abort_run($sformatf("error at %0t ns: beat %0d got %h expected %h",
						$time, delivered_cnt, rx_tdata, exp_beat));
				delivered_cnt++;
			end
			assert (accepted_cnt - delivered_cnt <= link_pkg::LINK_FIFO_DEPTH)
				else abort_run($sformatf("error at %0t ns: %0d beats outstanding", $time,
					accepted_cnt - delivered_cnt));
		end
	end

	// Hold-off length, online cycles counted up to the align flag
	always @(negedge clk)
	begin
		if (!ldr_online)
			holdoff_seen = 0;
		else if (!ldr_align_done)
			holdoff_seen++;
		else if (!align_prev)
			assert (holdoff_seen == exp_holdoff)
				else abort_run($sformatf("error at %0t ns: aligned after %0d cycles, expected %0d",
					$time, holdoff_seen, exp_holdoff));
		align_prev = ldr_align_done;
		assert (i_link_simplex_top.i_link_simplex_chk.err_count == 0)
			else abort_run("the bound checker flagged a protocol error");
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD_NS);
		abort_run("timeout, the link did not finish all phases in time");
	end

	initial
	begin
		seed      = SEED;
		tx_tdata  = '0;
		tx_tvalid = 1'b0;
		rx_tready = 1'b0;
		ldr_tx_en = '0;
		fol_tx_en = '0;
		delay_x   = '0;
		gen2_mode = 1'b1;
		@(posedge rst_n);
		repeat (2) @(negedge clk);
		assert (!tx_tready && !rx_tvalid && !ldr_online && !fol_online
		        && !ldr_align_done && !fol_align_done)
			else abort_run("outputs were not idle after reset");
		run_phase(1'b1, 16'd0, 0);
		run_phase(1'b1, 16'd13, 1);
		run_phase(1'b0, 16'd0, 2);
		run_phase(1'b0, 16'(MAX_DELAY), 3);
		repeat (4) @(negedge clk);
		if (i_link_simplex_top.i_link_simplex_chk.err_count != 0)
			abort_run("the bound checker flagged a protocol error");
		else
		begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

// File: files.f
link_pkg.sv
link_ctrl.sv
link_tx.sv
link_phy_wire.sv
link_fifo.sv
link_rx.sv
link_simplex_top.sv
link_simplex_chk.sv
tb_clk_gen.sv
tb_link_simplex.sv

// File: run_sim.sh
#!/bin/sh
# Builds the simplex link testbench with Verilator, runs it and
# decides pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_link_simplex -f files.f -o tb_link_simplex
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_link_simplex +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
